/* hdl/lsu_pkg.sv */
// lsu_pkg: data type and FSM state enums, execute command and memory bus structs
package lsu_pkg;

  // access size, code 2'b11 is decoded as byte
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // request FSM states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    PENDING_WO_EX_STALL,
    PENDING_W_EX_STALL_1,
    PENDING_W_EX_STALL_2
  } lsu_state_e;

  // one command from the execute stage
  typedef struct packed {
    logic        req;
    logic        we;
    data_type_e  dtype;
    logic        sign_ext;
    logic [1:0]  reg_offset;  // byte offset of the store data in the register
    logic        misaligned;  // this is the second part of a split access
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_cmd_t;

  // request toward the data memory
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // response from the data memory
  typedef struct packed {
    logic        gnt;     // combinational, same cycle as req
    logic        rvalid;  // one cycle after a granted load
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

/* hdl/lsu_write_align.sv */
// lsu_write_align: byte enables, store data rotation, misaligned access detection
`timescale 1ns/1ns

module lsu_write_align import lsu_pkg::*;
(
  input  lsu_cmd_t    cmd_i,
  output logic [3:0]  be_o,
  output logic [31:0] wdata_o,
  output logic        misaligned_o
);

  logic [1:0] addr_lo;
  logic [1:0] rot;

  assign addr_lo = cmd_i.addr[1:0];
  assign rot     = addr_lo - cmd_i.reg_offset;  // wraps mod 4

  // byte enables
  always_comb
  begin
    case (cmd_i.dtype)
      DT_WORD:
      begin
        if (!cmd_i.misaligned)
          be_o = 4'b1111 << addr_lo;           // upper part of the word
        else
          be_o = ~(4'b1111 << addr_lo);        // spill into next word
      end
      DT_HALF:
      begin
        if (!cmd_i.misaligned)
          be_o = 4'b0011 << addr_lo;           // offset 3 keeps only lane 3
        else
          be_o = 4'b0001;                      // second byte of a split half
      end
      default: be_o = 4'b0001 << addr_lo;     // byte, also code 11
    endcase
  end

  // rotate register data onto the addressed lanes
  always_comb
  begin
    case (rot)
      2'b00: wdata_o = cmd_i.wdata;
      2'b01: wdata_o = {cmd_i.wdata[23:0], cmd_i.wdata[31:24]};
      2'b10: wdata_o = {cmd_i.wdata[15:0], cmd_i.wdata[31:16]};
      default: wdata_o = {cmd_i.wdata[7:0], cmd_i.wdata[31:8]};
    endcase
  end

  // split access needed, never flagged for a second part
  always_comb
  begin
    misaligned_o = 1'b0;
    if (cmd_i.req && !cmd_i.misaligned)
    begin
      if (cmd_i.dtype == DT_WORD && addr_lo != 2'b00)
        misaligned_o = 1'b1;
      if (cmd_i.dtype == DT_HALF && addr_lo == 2'b11)
        misaligned_o = 1'b1;
    end
  end

endmodule

/* hdl/lsu_read_extend.sv */
// lsu_read_extend: load lane select, misaligned assembly, sign extension, rdata register
`timescale 1ns/1ns

module lsu_read_extend import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] rdata_i,     // raw word from memory
  input  logic        latch_i,     // response cycle of a load
  input  data_type_e  dtype_i,
  input  logic [1:0]  offset_i,    // address low bits of the access
  input  logic        sign_ext_i,
  input  logic        part_i,      // access was a second part
  output logic [31:0] rdata_o,
  output logic [31:0] data_reg_o
);

  logic [31:0] rdata_q;     // last result, or raw first beat
  logic [31:0] shifted;     // addressed lane moved to bit 0
  logic [31:0] word_asm;
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;
  logic [31:0] rdata_ext;
  logic        first_part;

  assign shifted = rdata_i >> {offset_i, 3'b000};

  // misaligned words take the low bytes of this beat on top
  always_comb
  begin
    case (offset_i)
      2'b00: word_asm = rdata_i;
      2'b01: word_asm = {rdata_i[7:0], rdata_q[31:8]};
      2'b10: word_asm = {rdata_i[15:0], rdata_q[31:16]};
      default: word_asm = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // half at offset 3 straddles two words
  assign half_raw = (offset_i == 2'b11) ? {rdata_i[7:0], rdata_q[31:24]} : shifted[15:0];
  assign byte_raw = shifted[7:0];

  //////////////////////////////////////////////////
  // sign / zero extension
  //////////////////////////////////////////////////

  always_comb
  begin
    case (dtype_i)
      DT_WORD: rdata_ext = word_asm;
      DT_HALF: rdata_ext = {{16{sign_ext_i & half_raw[15]}}, half_raw};
      default: rdata_ext = {{24{sign_ext_i & byte_raw[7]}}, byte_raw};  // byte, code 11
    endcase
  end

  // first beat of a split load is kept raw for assembly
  assign first_part = !part_i &&
                      ((dtype_i == DT_WORD && offset_i != 2'b00) ||
                       (dtype_i == DT_HALF && offset_i == 2'b11));

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (latch_i)
    begin
      if (first_part)
        rdata_q <= rdata_i;     // raw, upper bytes used next beat
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_o    = latch_i ? rdata_ext : rdata_q;  // bypass in response cycle
  assign data_reg_o = rdata_q;                         // for a stalled decode stage

endmodule

/* hdl/lsu_ctrl.sv */
// lsu_ctrl: request FSM, replay registers, pipelined ack and load attribute registers
`timescale 1ns/1ns

module lsu_ctrl import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  lsu_cmd_t    cmd_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  input  logic        ex_stall_i,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  output logic        ack_o,
  output logic        latch_o,       // response cycle of a load
  output data_type_e  dtype_q_o,
  output logic [1:0]  offset_q_o,
  output logic        sign_ext_q_o,
  output logic        part_q_o
);

  lsu_state_e state_q, state_n;
  mem_req_t   replay_q;      // held copy of an un-granted request
  logic       we_q;          // current access is a store
  logic       entered;       // new command taken into the FSM
  logic       stalled_req;   // request out, no grant

  assign stalled_req = mem_req_o.req && !mem_rsp_i.gnt;

  //////////////////////////////////////////////////
  // next state and bus request
  //////////////////////////////////////////////////

  always_comb
  begin
    state_n   = state_q;
    mem_req_o = '{req: 1'b0, we: cmd_i.we, be: be_i, addr: cmd_i.addr, wdata: wdata_i};
    latch_o   = 1'b0;
    entered   = 1'b0;

    case (state_q)
      IDLE, PENDING_WO_EX_STALL:
      begin
        latch_o       = (state_q == PENDING_WO_EX_STALL) && !we_q;
        mem_req_o.req = cmd_i.req;   // next request may overlap the response
        state_n       = IDLE;
        if (cmd_i.req)
        begin
          entered = 1'b1;
          if (mem_rsp_i.gnt)
            state_n = ex_stall_i ? PENDING_W_EX_STALL_1 : PENDING_WO_EX_STALL;
          else if (!ex_stall_i)
            state_n = WAIT_GNT;
        end
      end
      WAIT_GNT:
      begin
        mem_req_o     = replay_q;    // replay until taken
        mem_req_o.req = 1'b1;
        if (mem_rsp_i.gnt)
          state_n = PENDING_WO_EX_STALL;
      end
      PENDING_W_EX_STALL_1:
      begin
        latch_o = !we_q;             // capture result, no new request
        state_n = ex_stall_i ? PENDING_W_EX_STALL_2 : IDLE;
      end
      PENDING_W_EX_STALL_2:
        state_n = ex_stall_i ? PENDING_W_EX_STALL_2 : IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= IDLE;
      ack_o    <= 1'b0;
      replay_q <= '0;
    end
    else
    begin
      state_q <= state_n;
      ack_o   <= !stalled_req;        // low after an un-granted cycle
      if (stalled_req)
        replay_q <= mem_req_o;
    end
  end

  // load attributes, taken with the request
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      dtype_q_o    <= DT_WORD;
      offset_q_o   <= 2'b00;
      sign_ext_q_o <= 1'b0;
      part_q_o     <= 1'b0;
      we_q         <= 1'b0;
    end
    else if (entered)
    begin
      dtype_q_o    <= cmd_i.dtype;
      offset_q_o   <= cmd_i.addr[1:0];
      sign_ext_q_o <= cmd_i.sign_ext;
      part_q_o     <= cmd_i.misaligned;
      we_q         <= cmd_i.we;
    end
  end

  // a request parked in WAIT_GNT must not move on the bus
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (state_n == WAIT_GNT) |=> $stable(mem_req_o));

  // memory read-valid only in the response cycle of a granted load
  a_rvalid_on_latch: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_i.rvalid == latch_o);

endmodule

/* hdl/lsu.sv */
// lsu: load-store unit joining write aligner, request controller and read extender
`timescale 1ns/1ns

module lsu import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  lsu_cmd_t    cmd_i,
  input  logic        ex_stall_i,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  output logic [31:0] rdata_o,
  output logic [31:0] data_reg_o,
  output logic        ack_o,
  output logic        misaligned_o
);

  logic [3:0]  be;
  logic [31:0] wdata;
  logic        latch;
  data_type_e  dtype_q;
  logic [1:0]  offset_q;
  logic        sign_ext_q;
  logic        part_q;   // registered second-part flag of the command

  lsu_write_align u_align (
    .cmd_i        (cmd_i),
    .be_o         (be),
    .wdata_o      (wdata),
    .misaligned_o (misaligned_o)
  );

  lsu_ctrl u_ctrl (
    .clk (clk), .rst_n (rst_n),
    .cmd_i (cmd_i), .be_i (be), .wdata_i (wdata), .ex_stall_i (ex_stall_i),
    .mem_req_o (mem_req_o), .mem_rsp_i (mem_rsp_i),
    .ack_o (ack_o), .latch_o (latch),
    .dtype_q_o (dtype_q), .offset_q_o (offset_q),
    .sign_ext_q_o (sign_ext_q), .part_q_o (part_q)
  );

  lsu_read_extend u_extend (
    .clk (clk), .rst_n (rst_n),
    .rdata_i (mem_rsp_i.rdata), .latch_i (latch),
    .dtype_i (dtype_q), .offset_i (offset_q),
    .sign_ext_i (sign_ext_q), .part_i (part_q),
    .rdata_o (rdata_o), .data_reg_o (data_reg_o)
  );

endmodule

/* hdl/data_mem.sv */
// data_mem: single-port byte-enabled data memory with stallable grant
`timescale 1ns/1ns

module data_mem import lsu_pkg::*;
#(
  parameter int MEM_WORDS = 256
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t req_i,
  input  logic     stall_i,    // withholds grant
  output mem_rsp_t rsp_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [31:0]   mem_q [MEM_WORDS];   // no reset on contents
  logic [AW-1:0] idx;                 // upper address bits dropped
  logic          gnt;
  logic          rvalid_q;
  logic [31:0]   rdata_q;

  assign idx = req_i.addr[AW+1:2];
  assign gnt = req_i.req && !stall_i;

  //////////////////////////////////////////////////
  // array write, byte lanes
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (gnt && req_i.we)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (req_i.be[b])
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  // read port, data one cycle after grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end
    else
    begin
      rvalid_q <= gnt && !req_i.we;   // loads only
      if (gnt && !req_i.we)
        rdata_q <= mem_q[idx];
    end
  end

  assign rsp_o.gnt    = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

/* hdl/lsu_top.sv */
// lsu_top: load-store unit connected to the data memory
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*;
#(
  parameter int MEM_WORDS = 256
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  lsu_cmd_t    cmd_i,        // from execute stage
  input  logic        ex_stall_i,
  input  logic        mem_stall_i,  // memory side back-pressure
  output logic [31:0] rdata_o,
  output logic [31:0] data_reg_o,
  output logic        ack_o,
  output logic        misaligned_o
);

  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  lsu u_lsu (
    .clk (clk), .rst_n (rst_n),
    .cmd_i (cmd_i), .ex_stall_i (ex_stall_i),
    .mem_req_o (mem_req), .mem_rsp_i (mem_rsp),
    .rdata_o (rdata_o), .data_reg_o (data_reg_o),
    .ack_o (ack_o), .misaligned_o (misaligned_o)
  );

  data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (mem_req),
    .stall_i (mem_stall_i),
    .rsp_o   (mem_rsp)
  );

endmodule

/* bench/lsu_tb.sv */
// lsu_tb: directed tests for lsu_top with byte-level reference memory and watchdog
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*;
();

  localparam int MEM_WORDS       = 256;
  localparam int MEM_BYTES       = MEM_WORDS * 4;
  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int TIMEOUT_NS      = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  lsu_cmd_t    cmd_i;
  logic        ex_stall_i;
  logic        mem_stall_i;
  logic [31:0] rdata_o;
  logic [31:0] data_reg_o;
  logic        ack_o;
  logic        misaligned_o;

  logic [7:0]  model_mem [MEM_BYTES];  // mirror of every issued store
  int          errors = 0;
  int          checks = 0;

  lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) UUT (
    .clk (clk), .rst_n (rst_n),
    .cmd_i (cmd_i), .ex_stall_i (ex_stall_i), .mem_stall_i (mem_stall_i),
    .rdata_o (rdata_o), .data_reg_o (data_reg_o),
    .ack_o (ack_o), .misaligned_o (misaligned_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int access_size(input data_type_e dt);
    return (dt == DT_WORD) ? 4 : (dt == DT_HALF) ? 2 : 1;
  endfunction

  // register byte roff lands at addr, little endian upward
  function automatic void model_store(input logic [31:0] addr, input data_type_e dt,
                                      input logic [1:0] roff, input logic [31:0] wdata);
    for (int i = 0; i < access_size(dt); i++)
      model_mem[(addr + i) % MEM_BYTES] = wdata[8 * ((i + roff) % 4) +: 8];
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] addr, input data_type_e dt,
                                                input logic sext);
    logic [31:0] v;
    int          n;
    n = access_size(dt);
    v = '0;
    for (int i = 0; i < n; i++)
      v[8 * i +: 8] = model_mem[(addr + i) % MEM_BYTES];
    if (n == 2 && sext && v[15])
      v[31:16] = '1;   // half sign
    if (n == 1 && sext && v[7])
      v[31:8] = '1;    // byte sign
    return v;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_dropped(input logic dropped);
    checks++;
    assert (dropped)
    else
    begin
      $display("ack_o stayed high although the memory stall held a request, at %0t", $time);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // bus access
  //////////////////////////////////////////////////

  // one beat, ends in the response cycle (negedge)
  task automatic issue_beat(input lsu_cmd_t cmd, input int stall_cyc, input logic exs,
                            output logic [31:0] rd, output logic mis, output logic dropped);
    dropped = 1'b0;
    @(posedge clk);
    cmd_i       <= cmd;
    ex_stall_i  <= exs;
    mem_stall_i <= (stall_cyc > 0);
    @(negedge clk);
    mis = misaligned_o;            // combinational on the command
    @(posedge clk);
    cmd_i <= '0;                   // replay regs hold it if not granted
    if (stall_cyc > 0)
    begin
      repeat (stall_cyc - 1) @(posedge clk);
      mem_stall_i <= 1'b0;
    end
    @(negedge clk);
    while (!ack_o)                 // last cycle had no grant
    begin
      dropped = 1'b1;
      @(negedge clk);
    end
    rd = rdata_o;
  endtask

  task automatic access(input logic we, input data_type_e dt, input logic sext,
                        input logic [1:0] roff, input logic [31:0] addr, input logic [31:0] wdata,
                        input int stall_cyc, input logic exs,
                        output logic [31:0] rd, output logic mis, output logic dropped);
    lsu_cmd_t cmd;
    logic     mis2;
    logic     drop2;
    cmd = '{req: 1'b1, we: we, dtype: dt, sign_ext: sext, reg_offset: roff,
            misaligned: 1'b0, addr: addr, wdata: wdata};
    issue_beat(cmd, stall_cyc, exs, rd, mis, dropped);
    if (mis)
    begin
      cmd.misaligned = 1'b1;
      cmd.addr       = addr + 32'd4;   // offset bits kept, selects lanes
      issue_beat(cmd, 0, exs, rd, mis2, drop2);
      dropped = dropped | drop2;
    end
    if (we)
      model_store(addr, dt, roff, wdata);
  endtask

  task automatic do_store(input logic [31:0] addr, input data_type_e dt, input logic [1:0] roff,
                          input logic [31:0] wdata, input int stall_cyc,
                          output logic mis, output logic dropped);
    logic [31:0] rd;
    access(1'b1, dt, 1'b0, roff, addr, wdata, stall_cyc, 1'b0, rd, mis, dropped);
  endtask

  task automatic load_check(input logic [31:0] addr, input data_type_e dt, input logic sext,
                            input int stall_cyc, output logic mis, output logic dropped);
    logic [31:0] rd;
    access(1'b0, dt, sext, 2'b00, addr, 32'h0, stall_cyc, 1'b0, rd, mis, dropped);
    check_val($sformatf("load %0d bytes @%h", access_size(dt), addr),
              expected_load(addr, dt, sext), rd);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_aligned_words();
    logic mis;
    logic dr;
    for (int i = 0; i < 32; i++)   // fills 0x00..0x7f for later tests
      do_store(i * 4, DT_WORD, i % 4, $urandom, 0, mis, dr);
    for (int i = 0; i < 32; i++)
      load_check(i * 4, DT_WORD, 1'b0, 0, mis, dr);
  endtask

  task automatic test_narrow();
    logic mis;
    logic dr;
    for (int off = 0; off < 4; off++)
    begin
      do_store(32'h40 + off, DT_BYTE, $urandom_range(0, 3), $urandom, 0, mis, dr);
      load_check(32'h40 + off, DT_BYTE, 1'b0, 0, mis, dr);
      load_check(32'h40 + off, DT_BYTE, 1'b1, 0, mis, dr);
    end
    for (int off = 0; off < 3; off++)   // offset 3 is split, see next test
    begin
      do_store(32'h44 + off, DT_HALF, $urandom_range(0, 3), $urandom, 0, mis, dr);
      load_check(32'h44 + off, DT_HALF, 1'b0, 0, mis, dr);
      load_check(32'h44 + off, DT_HALF, 1'b1, 0, mis, dr);
    end
  endtask

  task automatic test_misaligned();
    logic [31:0] base;
    logic        mis;
    logic        dr;
    for (int off = 1; off < 4; off++)
    begin
      base = 32'h60 + 8 * (off - 1);
      do_store(base + off, DT_WORD, $urandom_range(0, 3), $urandom, 0, mis, dr);
      check_val("misaligned_o word store", 32'd1, {31'd0, mis});
      load_check(base, DT_WORD, 1'b0, 0, mis, dr);          // both touched words
      load_check(base + 4, DT_WORD, 1'b0, 0, mis, dr);
      load_check(base + off, DT_WORD, 1'b0, 0, mis, dr);    // assembled from two beats
      check_val("misaligned_o word load", 32'd1, {31'd0, mis});
    end
    do_store(32'h7b, DT_HALF, $urandom_range(0, 3), $urandom, 0, mis, dr);
    check_val("misaligned_o half store", 32'd1, {31'd0, mis});
    load_check(32'h78, DT_WORD, 1'b0, 0, mis, dr);
    load_check(32'h7c, DT_WORD, 1'b0, 0, mis, dr);
    load_check(32'h7b, DT_HALF, 1'b1, 0, mis, dr);
    check_val("misaligned_o half load", 32'd1, {31'd0, mis});
    load_check(32'h7b, DT_HALF, 1'b0, 0, mis, dr);
  endtask

  task automatic test_mem_stall();
    logic [31:0] addr;
    logic        mis;
    logic        dr;
    for (int i = 0; i < 4; i++)
    begin
      addr = $urandom_range(0, 31) * 4 + $urandom_range(0, 1) * 2;
      do_store(addr, (i % 2) ? DT_BYTE : DT_HALF, $urandom_range(0, 3), $urandom,
               $urandom_range(2, 6), mis, dr);
      check_dropped(dr);
      load_check({addr[31:2], 2'b00}, DT_WORD, 1'b0, $urandom_range(1, 5), mis, dr);
      check_dropped(dr);   // neighbours checked through the whole word
    end
  endtask

  task automatic test_ex_stall();
    logic [31:0] rd;
    logic [31:0] exp;
    logic        mis;
    logic        dr;
    exp = expected_load(32'h10, DT_WORD, 1'b0);
    access(1'b0, DT_WORD, 1'b0, 2'b00, 32'h10, 32'h0, 0, 1'b1, rd, mis, dr);
    check_val("load under ex stall", exp, rd);
    @(posedge clk);
    cmd_i <= '{req: 1'b1, we: 1'b1, dtype: DT_WORD, sign_ext: 1'b0, reg_offset: 2'b00,
               misaligned: 1'b0, addr: 32'h10, wdata: ~exp};   // must not reach memory
    for (int k = 0; k < 5; k++)
    begin
      @(negedge clk);
      check_val("data_reg_o during ex stall", exp, data_reg_o);
      @(posedge clk);
    end
    cmd_i      <= '0;   // withdrawn before release
    ex_stall_i <= 1'b0;
    load_check(32'h10, DT_WORD, 1'b0, 0, mis, dr);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(7963));
    cmd_i       = '0;
    ex_stall_i  = 1'b0;
    mem_stall_i = 1'b0;
    rst_n       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    check_val("ack_o in reset", 32'd0, {31'd0, ack_o});
    rst_n <= 1'b1;
    test_aligned_words();
    test_narrow();
    test_misaligned();
    test_mem_stall();
    test_ex_stall();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog: the run timed out after %0d ns, errors so far %0d", TIMEOUT_NS, errors);
    $display("tests failed");
    $finish;
  end

endmodule

/* src.f */
hdl/lsu_pkg.sv
hdl/lsu_write_align.sv
hdl/lsu_read_extend.sv
hdl/lsu_ctrl.sv
hdl/lsu.sv
hdl/data_mem.sv
hdl/lsu_top.sv
bench/lsu_tb.sv
